// File: icache_pkg.sv
// Shared widths and encodings for the instruction cache.
// Imported by every cache module; the geometry here is fixed for the
// whole design, only the set count is a module parameter.

package icache_pkg;

  // associativity, also the number of dwords in a block
  localparam int WAYS = 4;

  localparam int BLOCK_OFFSET_W = 5;
  localparam int PAGE_OFFSET_W = 12;

  typedef logic [31:0] paddr_t;

  // page tag is everything above the untranslated offset
  typedef logic [$bits(paddr_t)-PAGE_OFFSET_W-1:0] ptag_t;
  typedef logic [PAGE_OFFSET_W-1:0] page_offset_t;

  typedef logic [63:0] dword_t;
  typedef logic [31:0] instr_t;
  typedef logic [WAYS*$bits(dword_t)-1:0] block_t;

  typedef logic [$clog2(WAYS)-1:0] way_t;

  // opcodes of the fill engine's tag packets
  typedef enum logic [1:0] {
    TAG_OP_CLEAR_SET  = 2'd0,
    TAG_OP_INVALIDATE = 2'd1,
    TAG_OP_SET_TAG    = 2'd2
  } tag_op_e;

endpackage

// File: icache_tag_array.sv
// Tag store and valid bits of the instruction cache.
// A read strobe returns every way of one set on the next cycle.
// Tag packets from the fill engine clear a set, drop a way or install a tag.

`timescale 1ns/100ps

module icache_tag_array
  import icache_pkg::*;
  #(parameter int sets_p = 16,
    localparam int index_w_lp = $clog2(sets_p)
  ) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  rd_v_i,
  input  logic [index_w_lp-1:0] rd_index_i,

  input  logic                  tag_pkt_v_i,
  input  tag_op_e               tag_pkt_op_i,
  input  logic [index_w_lp-1:0] tag_pkt_index_i,
  input  way_t                  tag_pkt_way_i,
  input  ptag_t                 tag_pkt_tag_i,

  output ptag_t [WAYS-1:0]      tags_o,
  output logic  [WAYS-1:0]      valid_o
);

  ptag_t [WAYS-1:0] tag_mem [sets_p];
  logic [sets_p-1:0][WAYS-1:0] valid_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
    end else if (tag_pkt_v_i) begin
      case (tag_pkt_op_i)
        TAG_OP_CLEAR_SET: valid_r[tag_pkt_index_i] <= '0;
        TAG_OP_INVALIDATE: valid_r[tag_pkt_index_i][tag_pkt_way_i] <= 1'b0;
        TAG_OP_SET_TAG: valid_r[tag_pkt_index_i][tag_pkt_way_i] <= 1'b1;
        default: begin
        end
      endcase
    end
  end

  // tag bits only change on a set-tag packet
  always_ff @(posedge clk_i) begin
    if (tag_pkt_v_i && (tag_pkt_op_i == TAG_OP_SET_TAG)) begin
      tag_mem[tag_pkt_index_i][tag_pkt_way_i] <= tag_pkt_tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      tags_o  <= tag_mem[rd_index_i];
      valid_o <= valid_r[rd_index_i];
    end
  end

endmodule

// File: icache_data_array.sv
// Data store of the instruction cache, one dword bank per way.
// Dword k of way w sits in bank k^w, so a lookup reads word k of all ways
// in one cycle and a fill writes a whole block in one cycle.
// Read data appears the cycle after the read strobe.

`timescale 1ns/100ps

module icache_data_array
  import icache_pkg::*;
  #(parameter int sets_p = 16,
    localparam int index_w_lp = $clog2(sets_p),
    localparam int word_w_lp = $clog2(WAYS)
  ) (
  input  logic                  clk_i,

  input  logic                  rd_v_i,
  input  logic [index_w_lp-1:0] rd_index_i,
  input  logic [word_w_lp-1:0]  rd_word_i,

  input  logic                  wr_v_i,
  input  logic [index_w_lp-1:0] wr_index_i,
  input  way_t                  wr_way_i,
  input  block_t                wr_block_i,

  output dword_t [WAYS-1:0]     rd_data_o
);

  localparam int rows_lp = sets_p * WAYS;
  localparam int dword_w_lp = $bits(dword_t);

  for (genvar b = 0; b < WAYS; b++) begin : g_bank
    dword_t mem_r [rows_lp];
    dword_t rd_r;
    logic [word_w_lp-1:0] wr_word;

    // block word this bank holds for the way being filled
    assign wr_word = wr_way_i ^ word_w_lp'(b);

    always_ff @(posedge clk_i) begin
      if (wr_v_i) begin
        mem_r[{wr_index_i, wr_word}] <= wr_block_i[wr_word*dword_w_lp +: dword_w_lp];
      end
      if (rd_v_i) begin
        rd_r <= mem_r[{rd_index_i, rd_word_i}];
      end
    end

    assign rd_data_o[b] = rd_r;
  end

endmodule

// File: icache_lru.sv
// Tree pseudo-LRU state of the instruction cache, WAYS-1 bits per set.
// Node 0 is the root, node n has children 2n+1 (lower) and 2n+2 (upper).
// Each bit points at the less recently used half, 0 for the lower one.
// The victim of the addressed set is encoded combinationally; a hit
// points the bits on its path away from the hit way.

`timescale 1ns/100ps

module icache_lru
  import icache_pkg::*;
  #(parameter int sets_p = 16,
    localparam int index_w_lp = $clog2(sets_p)
  ) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic [index_w_lp-1:0] index_i,
  input  logic                  hit_v_i,
  input  way_t                  hit_way_i,

  output way_t                  victim_o
);

  localparam int levels_lp = $clog2(WAYS);

  logic [sets_p-1:0][WAYS-2:0] lru_r;
  logic [WAYS-2:0] bits_cur;
  logic [WAYS-2:0] bits_upd;

  assign bits_cur = lru_r[index_i];

  // walk from the root following the pointers
  always_comb begin : encode
    int node;
    node = 0;
    victim_o = '0;
    for (int l = 0; l < levels_lp; l++) begin
      victim_o[levels_lp-1-l] = bits_cur[node];
      node = 2*node + 1 + int'(bits_cur[node]);
    end
  end

  always_comb begin : update
    int node;
    node = 0;
    bits_upd = bits_cur;
    for (int l = 0; l < levels_lp; l++) begin
      bits_upd[node] = ~hit_way_i[levels_lp-1-l];
      node = 2*node + 1 + int'(hit_way_i[levels_lp-1-l]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lru_r <= '0;
    end else if (hit_v_i) begin
      lru_r[index_i] <= bits_upd;
    end
  end

endmodule

// File: icache_lookup.sv
// Fetch pipeline of the instruction cache.
// TL holds the page offset of an accepted fetch while the arrays are read;
// TV joins it with the page tag and registers the array outputs.
// In TV the tags are compared and the hitting instruction is selected.
// Fetches without a translation or with poison are dropped at the TL edge.

`timescale 1ns/100ps

module icache_lookup
  import icache_pkg::*;
  (
  input  logic              clk_i,
  input  logic              reset_i,

  input  paddr_t            vaddr_i,
  input  logic              accept_i,

  input  ptag_t             ptag_i,
  input  logic              ptag_v_i,
  input  logic              poison_i,

  input  ptag_t  [WAYS-1:0] tags_i,
  input  logic   [WAYS-1:0] valid_i,
  input  dword_t [WAYS-1:0] rd_data_i,

  output logic              tv_v_o,
  output logic              tv_hit_o,
  output way_t              hit_way_o,
  output paddr_t            tv_paddr_o,
  output logic   [WAYS-1:0] tv_valid_o,

  output instr_t            data_o,
  output logic              data_v_o
);

  localparam int word_w_lp = $clog2(WAYS);
  localparam int byte_w_lp = BLOCK_OFFSET_W - word_w_lp;
  localparam int instr_w_lp = $bits(instr_t);

  logic tl_v_r;
  page_offset_t tl_offset_r;

  logic tv_we;
  logic tv_v_r;
  paddr_t tv_paddr_r;
  ptag_t  [WAYS-1:0] tv_tags_r;
  logic   [WAYS-1:0] tv_valid_r;
  dword_t [WAYS-1:0] tv_data_r;

  logic [WAYS-1:0] hit_vec;
  logic [word_w_lp-1:0] tv_word;
  way_t bank_sel;
  dword_t hit_dword;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r <= 1'b0;
    end else begin
      tl_v_r <= accept_i;
    end
  end

  // only the untranslated bits are needed past TL
  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      tl_offset_r <= vaddr_i[PAGE_OFFSET_W-1:0];
    end
  end

  assign tv_we = tl_v_r & ptag_v_i & ~poison_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tv_v_r <= 1'b0;
    end else begin
      tv_v_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_we) begin
      tv_paddr_r <= {ptag_i, tl_offset_r};
      tv_tags_r  <= tags_i;
      tv_valid_r <= valid_i;
      tv_data_r  <= rd_data_i;
    end
  end

  for (genvar w = 0; w < WAYS; w++) begin : g_cmp
    assign hit_vec[w] = tv_valid_r[w]
      & (tv_tags_r[w] == tv_paddr_r[$bits(paddr_t)-1:PAGE_OFFSET_W]);
  end

  // lowest hitting way wins
  always_comb begin
    hit_way_o = '0;
    for (int w = WAYS-1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way_o = way_t'(w);
      end
    end
  end

  assign tv_word = tv_paddr_r[byte_w_lp +: word_w_lp];
  assign bank_sel = hit_way_o ^ tv_word;
  assign hit_dword = tv_data_r[bank_sel];

  // address bit 2 picks the instruction half
  assign data_o = tv_paddr_r[byte_w_lp-1]
    ? hit_dword[instr_w_lp +: instr_w_lp]
    : hit_dword[0 +: instr_w_lp];

  assign tv_hit_o   = |hit_vec;
  assign data_v_o   = tv_v_r & tv_hit_o;
  assign tv_v_o     = tv_v_r;
  assign tv_paddr_o = tv_paddr_r;
  assign tv_valid_o = tv_valid_r;

endmodule

// File: icache_miss_ctrl.sv
// Miss handling of the instruction cache.
// A missing TV fetch raises a block request; the replacement way follows
// one cycle later with the metadata valid. Fetch acceptance stalls from
// the request until the fill engine signals completion.

`timescale 1ns/100ps

module icache_miss_ctrl
  import icache_pkg::*;
  (
  input  logic            clk_i,
  input  logic            reset_i,

  input  logic            tv_v_i,
  input  logic            tv_hit_i,
  input  paddr_t          tv_paddr_i,
  input  logic [WAYS-1:0] tv_valid_i,
  input  way_t            lru_victim_i,

  input  logic            cache_req_ready_i,
  input  logic            cache_req_complete_i,
  input  logic            vaddr_v_i,

  output logic            cache_req_v_o,
  output paddr_t          cache_req_addr_o,
  output logic            cache_req_metadata_v_o,
  output way_t            repl_way_o,

  output logic            miss_o,
  output logic            vaddr_ready_o,
  output logic            accept_o
);

  logic miss_tv;
  logic pending_r;
  logic miss_busy;
  logic inv_exist;
  way_t inv_way;

  assign miss_tv = tv_v_i & ~tv_hit_i;

  // a second miss behind an outstanding one is only reported
  assign cache_req_v_o = miss_tv & cache_req_ready_i & ~pending_r;
  assign cache_req_addr_o = {tv_paddr_i[$bits(paddr_t)-1:BLOCK_OFFSET_W],
                             {BLOCK_OFFSET_W{1'b0}}};

  always_comb begin
    inv_exist = 1'b0;
    inv_way = '0;
    for (int w = WAYS-1; w >= 0; w--) begin
      if (!tv_valid_i[w]) begin
        inv_exist = 1'b1;
        inv_way = way_t'(w);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cache_req_metadata_v_o <= 1'b0;
      pending_r <= 1'b0;
    end else begin
      cache_req_metadata_v_o <= cache_req_v_o;
      if (cache_req_v_o) begin
        pending_r <= 1'b1;
      end else if (cache_req_complete_i) begin
        pending_r <= 1'b0;
      end
    end
  end

  // invalid ways fill before anything is evicted
  always_ff @(posedge clk_i) begin
    if (cache_req_v_o) begin
      repl_way_o <= inv_exist ? inv_way : lru_victim_i;
    end
  end

  assign miss_busy = cache_req_v_o | pending_r;
  assign vaddr_ready_o = cache_req_ready_i & ~miss_busy;
  assign accept_o = vaddr_v_i & vaddr_ready_o;
  assign miss_o = miss_tv;

endmodule

// File: icache.sv
// Top level of the virtually indexed, physically tagged instruction cache.
// Connects the fetch pipeline, the tag, data and LRU arrays and the miss
// controller. Arrays are read with the index of the accepted fetch; fill
// packets are applied only in cycles where no fetch is accepted.

`timescale 1ns/100ps

module icache
  import icache_pkg::*;
  #(parameter int sets_p = 16,
    localparam int index_w_lp = $clog2(sets_p)
  ) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  paddr_t                vaddr_i,
  input  logic                  vaddr_v_i,
  output logic                  vaddr_ready_o,

  input  ptag_t                 ptag_i,
  input  logic                  ptag_v_i,
  input  logic                  poison_i,

  output instr_t                data_o,
  output logic                  data_v_o,
  output logic                  miss_o,

  output paddr_t                cache_req_addr_o,
  output logic                  cache_req_v_o,
  input  logic                  cache_req_ready_i,
  output logic                  cache_req_metadata_v_o,
  output way_t                  repl_way_o,
  input  logic                  cache_req_complete_i,

  input  logic                  tag_pkt_v_i,
  input  tag_op_e               tag_pkt_op_i,
  input  logic [index_w_lp-1:0] tag_pkt_index_i,
  input  way_t                  tag_pkt_way_i,
  input  ptag_t                 tag_pkt_tag_i,

  input  logic                  data_pkt_v_i,
  input  logic [index_w_lp-1:0] data_pkt_index_i,
  input  way_t                  data_pkt_way_i,
  input  block_t                data_pkt_block_i,

  output logic                  fill_ready_o
);

  localparam int word_w_lp = $clog2(WAYS);

  logic accept;
  logic [index_w_lp-1:0] rd_index;
  logic [word_w_lp-1:0] rd_word;

  ptag_t  [WAYS-1:0] tags;
  logic   [WAYS-1:0] valids;
  dword_t [WAYS-1:0] rd_data;

  logic tv_v;
  logic tv_hit;
  way_t hit_way;
  paddr_t tv_paddr;
  logic [WAYS-1:0] tv_valid;
  way_t lru_victim;

  assign rd_index = vaddr_i[BLOCK_OFFSET_W +: index_w_lp];
  assign rd_word = vaddr_i[BLOCK_OFFSET_W-word_w_lp +: word_w_lp];
  assign fill_ready_o = ~accept;

  icache_lookup u_lookup (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .vaddr_i    (vaddr_i),
    .accept_i   (accept),
    .ptag_i     (ptag_i),
    .ptag_v_i   (ptag_v_i),
    .poison_i   (poison_i),
    .tags_i     (tags),
    .valid_i    (valids),
    .rd_data_i  (rd_data),
    .tv_v_o     (tv_v),
    .tv_hit_o   (tv_hit),
    .hit_way_o  (hit_way),
    .tv_paddr_o (tv_paddr),
    .tv_valid_o (tv_valid),
    .data_o     (data_o),
    .data_v_o   (data_v_o)
  );

  icache_tag_array #(.sets_p(sets_p)) u_tag_array (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .rd_v_i          (accept),
    .rd_index_i      (rd_index),
    .tag_pkt_v_i     (tag_pkt_v_i & fill_ready_o),
    .tag_pkt_op_i    (tag_pkt_op_i),
    .tag_pkt_index_i (tag_pkt_index_i),
    .tag_pkt_way_i   (tag_pkt_way_i),
    .tag_pkt_tag_i   (tag_pkt_tag_i),
    .tags_o          (tags),
    .valid_o         (valids)
  );

  icache_data_array #(.sets_p(sets_p)) u_data_array (
    .clk_i      (clk_i),
    .rd_v_i     (accept),
    .rd_index_i (rd_index),
    .rd_word_i  (rd_word),
    .wr_v_i     (data_pkt_v_i & fill_ready_o),
    .wr_index_i (data_pkt_index_i),
    .wr_way_i   (data_pkt_way_i),
    .wr_block_i (data_pkt_block_i),
    .rd_data_o  (rd_data)
  );

  // LRU is indexed by the TV set and updated on its hit
  icache_lru #(.sets_p(sets_p)) u_lru (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .index_i   (tv_paddr[BLOCK_OFFSET_W +: index_w_lp]),
    .hit_v_i   (tv_v & tv_hit),
    .hit_way_i (hit_way),
    .victim_o  (lru_victim)
  );

  icache_miss_ctrl u_miss_ctrl (
    .clk_i                  (clk_i),
    .reset_i                (reset_i),
    .tv_v_i                 (tv_v),
    .tv_hit_i               (tv_hit),
    .tv_paddr_i             (tv_paddr),
    .tv_valid_i             (tv_valid),
    .lru_victim_i           (lru_victim),
    .cache_req_ready_i      (cache_req_ready_i),
    .cache_req_complete_i   (cache_req_complete_i),
    .vaddr_v_i              (vaddr_v_i),
    .cache_req_v_o          (cache_req_v_o),
    .cache_req_addr_o       (cache_req_addr_o),
    .cache_req_metadata_v_o (cache_req_metadata_v_o),
    .repl_way_o             (repl_way_o),
    .miss_o                 (miss_o),
    .vaddr_ready_o          (vaddr_ready_o),
    .accept_o               (accept)
  );

endmodule

// File: icache_tb.sv
// Testbench of the instruction cache.
// Drives fetches one at a time, models the fill engine and keeps a
// reference copy of tags, valid bits and tree LRU bits to predict hits,
// data and replacement ways. Run with icache_tb as top.

`timescale 1ns/100ps

module icache_tb
  import icache_pkg::*;
  ();

  localparam int sets_lp = 16;
  localparam int index_w_lp = $clog2(sets_lp);
  // about 200 random fetches of up to ~25 cycles plus the directed tests
  localparam int max_cycles_lp = 20000;

  logic clk_i, reset_i;
  paddr_t vaddr_i;
  logic vaddr_v_i, vaddr_ready_o;
  ptag_t ptag_i;
  logic ptag_v_i, poison_i;
  instr_t data_o;
  logic data_v_o, miss_o;
  paddr_t cache_req_addr_o;
  logic cache_req_v_o, cache_req_ready_i, cache_req_metadata_v_o;
  way_t repl_way_o;
  logic cache_req_complete_i;
  logic tag_pkt_v_i;
  tag_op_e tag_pkt_op_i;
  logic [index_w_lp-1:0] tag_pkt_index_i, data_pkt_index_i;
  way_t tag_pkt_way_i, data_pkt_way_i;
  ptag_t tag_pkt_tag_i;
  logic data_pkt_v_i;
  block_t data_pkt_block_i;
  logic fill_ready_o;

  // reference state
  logic mdl_valid [sets_lp][WAYS];
  ptag_t mdl_tag [sets_lp][WAYS];
  logic [WAYS-2:0] mdl_lru [sets_lp];
  paddr_t expect_q [$];
  way_t exp_repl, last_repl;
  integer seed;
  int errors, tests, passed, test_start_errors, req_count, cycles;

  icache #(.sets_p(sets_lp)) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= max_cycles_lp) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles_lp);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic dword_t ref_dword(paddr_t a);
    logic [31:0] da;
    da = {a[31:3], 3'b000};
    return {~da, da};
  endfunction

  function automatic instr_t ref_instr(paddr_t a);
    dword_t d;
    d = ref_dword(a);
    return a[2] ? d[63:32] : d[31:0];
  endfunction

  // follow the pointers from the root
  function automatic way_t lru_victim(logic [WAYS-2:0] b);
    if (!b[0]) return b[1] ? way_t'(1) : way_t'(0);
    return b[2] ? way_t'(3) : way_t'(2);
  endfunction

  function automatic logic [WAYS-2:0] lru_touch(logic [WAYS-2:0] b, way_t w);
    b[0] = ~w[1];
    if (w[1]) b[2] = ~w[0];
    else b[1] = ~w[0];
    return b;
  endfunction

  function automatic way_t expected_repl(int set);
    for (int w = 0; w < WAYS; w++) begin
      if (!mdl_valid[set][w]) return way_t'(w);
    end
    return lru_victim(mdl_lru[set]);
  endfunction

  function automatic int find_way(paddr_t a);
    int set;
    set = int'(a[BLOCK_OFFSET_W +: index_w_lp]);
    for (int w = 0; w < WAYS; w++) begin
      if (mdl_valid[set][w] && mdl_tag[set][w] == a[31:PAGE_OFFSET_W]) return w;
    end
    return -1;
  endfunction

  function automatic paddr_t make_paddr(ptag_t tag, int set, int word, bit half);
    paddr_t pa;
    pa = {tag, {PAGE_OFFSET_W{1'b0}}};
    pa[BLOCK_OFFSET_W +: index_w_lp] = index_w_lp'(set);
    pa[4:3] = 2'(word);
    pa[2] = half;
    return pa;
  endfunction

  function automatic block_t make_block(paddr_t base);
    block_t blk;
    for (int k = 0; k < WAYS; k++) begin
      blk[k*64 +: 64] = ref_dword(base + paddr_t'(k*8));
    end
    return blk;
  endfunction

  task automatic check_equal(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(string name);
    int n;
    n = errors - test_start_errors;
    tests++;
    if (n == 0) passed++;
    $display("%s: %s (%0d errors)", name, (n == 0) ? "ok" : "failed", n);
    test_start_errors = errors;
  endtask

  task automatic do_fetch(input ptag_t tag, input int set, input int word, input bit half,
                          input bit pv, input bit poison, input bit drop_ready,
                          output bit hit, output bit missed);
    paddr_t pa;
    pa = make_paddr(tag, set, word, half);
    vaddr_i = {tag ^ 20'h5a5a5, pa[PAGE_OFFSET_W-1:0]};
    vaddr_v_i = 1'b1;
    do @(negedge clk_i); while (!vaddr_ready_o);
    @(posedge clk_i);
    #1;
    // TL cycle
    vaddr_v_i = 1'b0;
    ptag_i = tag;
    ptag_v_i = pv;
    poison_i = poison;
    if (pv && !poison) expect_q.push_back(pa);
    if (drop_ready) cache_req_ready_i = 1'b0;
    @(posedge clk_i);
    #1;
    ptag_v_i = 1'b0;
    poison_i = 1'b0;
    @(negedge clk_i);
    hit = data_v_o;
    missed = miss_o;
    @(posedge clk_i);
    #1;
    cache_req_ready_i = 1'b1;
  endtask

  task automatic fetch_until_hit(ptag_t tag, int set, int word, bit half);
    bit hit, missed;
    do_fetch(tag, set, word, half, 1'b1, 1'b0, 1'b0, hit, missed);
    assert (hit || missed) else begin
      $display("error: accepted fetch returned neither data nor a miss");
      errors++;
    end
    if (missed) begin
      // replay once the fill is done
      do_fetch(tag, set, word, half, 1'b1, 1'b0, 1'b0, hit, missed);
      check_equal("replay data_v_o", hit, 1);
    end
  endtask

  task automatic send_invalidate(int set, way_t way);
    bit applied;
    tag_pkt_v_i = 1'b1;
    tag_pkt_op_i = TAG_OP_INVALIDATE;
    tag_pkt_index_i = index_w_lp'(set);
    tag_pkt_way_i = way;
    applied = 1'b0;
    while (!applied) begin
      @(negedge clk_i);
      applied = fill_ready_o;
      @(posedge clk_i);
    end
    mdl_valid[set][way] = 1'b0;
    #1;
    tag_pkt_v_i = 1'b0;
  endtask

  // fill engine: set-tag and data packet into the reported way, then completion
  initial begin : fill_engine
    paddr_t req_addr;
    way_t way;
    int set;
    bit applied;
    forever begin
      @(negedge clk_i);
      if (cache_req_v_o) begin
        req_addr = cache_req_addr_o;
        set = int'(req_addr[BLOCK_OFFSET_W +: index_w_lp]);
        @(negedge clk_i);
        assert (cache_req_metadata_v_o) else begin
          $display("error: metadata valid did not follow the miss request");
          errors++;
        end
        way = repl_way_o;
        check_equal("repl_way_o", way, exp_repl);
        repeat (1 + ($unsigned($random(seed)) % 4)) @(posedge clk_i);
        #1;
        tag_pkt_v_i = 1'b1;
        tag_pkt_op_i = TAG_OP_SET_TAG;
        tag_pkt_index_i = index_w_lp'(set);
        tag_pkt_way_i = way;
        tag_pkt_tag_i = req_addr[31:PAGE_OFFSET_W];
        data_pkt_v_i = 1'b1;
        data_pkt_index_i = index_w_lp'(set);
        data_pkt_way_i = way;
        data_pkt_block_i = make_block(req_addr);
        applied = 1'b0;
        while (!applied) begin
          @(negedge clk_i);
          applied = fill_ready_o;
          @(posedge clk_i);
        end
        mdl_valid[set][way] = 1'b1;
        mdl_tag[set][way] = req_addr[31:PAGE_OFFSET_W];
        #1;
        tag_pkt_v_i = 1'b0;
        data_pkt_v_i = 1'b0;
        cache_req_complete_i = 1'b1;
        @(posedge clk_i);
        #1;
        cache_req_complete_i = 1'b0;
        last_repl = way;
      end
    end
  end

  // compare every lookup result with the reference model
  always @(negedge clk_i) begin : compare
    paddr_t a;
    int set;
    int w;
    if (data_v_o || miss_o) begin
      assert (expect_q.size() != 0) else begin
        $display("error: lookup result without an accepted fetch");
        errors++;
      end
      if (expect_q.size() != 0) begin
        a = expect_q.pop_front();
        set = int'(a[BLOCK_OFFSET_W +: index_w_lp]);
        w = find_way(a);
        check_equal("data_v_o", data_v_o, w >= 0);
        if (data_v_o) begin
          check_equal("data_o", data_o, ref_instr(a));
          if (w >= 0) mdl_lru[set] = lru_touch(mdl_lru[set], way_t'(w));
        end
        if (cache_req_v_o) begin
          req_count++;
          check_equal("cache_req_addr_o", cache_req_addr_o, {a[31:5], 5'b00000});
          exp_repl = expected_repl(set);
        end
      end
    end else begin
      assert (!cache_req_v_o) else begin
        $display("error: miss request raised without a missing fetch");
        errors++;
      end
    end
  end

  initial begin : stimulus
    bit hit, missed;
    int reqs;
    ptag_t t;
    int sets [3];
    seed = 72;
    {vaddr_i, vaddr_v_i, ptag_i, ptag_v_i, poison_i} = '0;
    cache_req_ready_i = 1'b1;
    cache_req_complete_i = 1'b0;
    {tag_pkt_v_i, tag_pkt_index_i, tag_pkt_way_i, tag_pkt_tag_i} = '0;
    tag_pkt_op_i = TAG_OP_CLEAR_SET;
    {data_pkt_v_i, data_pkt_index_i, data_pkt_way_i, data_pkt_block_i} = '0;
    for (int s = 0; s < sets_lp; s++) begin
      mdl_lru[s] = '0;
      for (int w = 0; w < WAYS; w++) mdl_valid[s][w] = 1'b0;
    end
    reset_i = 1'b1;
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    @(negedge clk_i);
    check_equal("data_v_o", data_v_o, 0);
    check_equal("miss_o", miss_o, 0);
    check_equal("cache_req_v_o", cache_req_v_o, 0);
    check_equal("cache_req_metadata_v_o", cache_req_metadata_v_o, 0);
    check_equal("vaddr_ready_o", vaddr_ready_o, 1);
    @(posedge clk_i);
    #1;
    cache_req_ready_i = 1'b0;
    @(negedge clk_i);
    check_equal("vaddr_ready_o", vaddr_ready_o, 0);
    @(posedge clk_i);
    #1;
    cache_req_ready_i = 1'b1;
    finish_test("reset state");

    reqs = req_count;
    do_fetch(20'h00abc, 3, 1, 1'b0, 1'b1, 1'b0, 1'b0, hit, missed);
    check_equal("miss_o", missed, 1);
    check_equal("request count", req_count, reqs + 1);
    for (int w = 0; w < WAYS; w++) begin
      for (int h = 0; h < 2; h++) begin
        do_fetch(20'h00abc, 3, w, h[0], 1'b1, 1'b0, 1'b0, hit, missed);
        check_equal("data_v_o", hit, 1);
      end
    end
    check_equal("request count", req_count, reqs + 1);
    finish_test("cold miss, fill and hit");

    for (int i = 0; i < WAYS; i++) begin
      fetch_until_hit(20'h10000 + 20'(i), 9, 0, 1'b0);
      check_equal("fill way", last_repl, i);
    end
    // touch ways 0 and 2 before the eviction
    fetch_until_hit(20'h10000, 9, 2, 1'b1);
    fetch_until_hit(20'h10002, 9, 3, 1'b0);
    fetch_until_hit(20'h10004, 9, 1, 1'b1);
    // way 1 is the victim after hits on 0, 1, 2, 3, 0 and 2
    check_equal("fifth tag way", last_repl, 1);
    finish_test("replacement order");

    t = mdl_tag[9][2];
    send_invalidate(9, 2'd2);
    do_fetch(t, 9, 0, 1'b1, 1'b1, 1'b0, 1'b0, hit, missed);
    check_equal("miss_o", missed, 1);
    do_fetch(t, 9, 0, 1'b1, 1'b1, 1'b0, 1'b0, hit, missed);
    check_equal("data_v_o", hit, 1);
    check_equal("replacement after invalidate", last_repl, 2);
    finish_test("invalidation");

    reqs = req_count;
    do_fetch(20'h00abc, 3, 2, 1'b1, 1'b1, 1'b1, 1'b0, hit, missed);
    check_equal("poisoned data_v_o", hit, 0);
    do_fetch(20'h3f000, 5, 0, 1'b0, 1'b0, 1'b0, 1'b0, hit, missed);
    check_equal("untranslated miss_o", missed, 0);
    check_equal("request count", req_count, reqs);
    @(posedge clk_i);
    #1;
    cache_req_ready_i = 1'b0;
    vaddr_v_i = 1'b1;
    repeat (6) begin
      @(negedge clk_i);
      check_equal("vaddr_ready_o", vaddr_ready_o, 0);
      check_equal("fill_ready_o", fill_ready_o, 1);
      check_equal("cache_req_v_o", cache_req_v_o, 0);
    end
    @(posedge clk_i);
    #1;
    vaddr_v_i = 1'b0;
    cache_req_ready_i = 1'b1;
    // miss seen while the request port is stalled
    do_fetch(20'h30000, 4, 0, 1'b0, 1'b1, 1'b0, 1'b1, hit, missed);
    check_equal("stalled miss_o", missed, 1);
    check_equal("request count", req_count, reqs);
    fetch_until_hit(20'h30000, 4, 0, 1'b0);
    check_equal("request count", req_count, reqs + 1);
    finish_test("poison and back-pressure");

    sets = '{1, 6, 14};
    for (int n = 0; n < 200; n++) begin
      fetch_until_hit(20'h20000 + 20'($unsigned($random(seed)) % 6),
                      sets[$unsigned($random(seed)) % 3],
                      $unsigned($random(seed)) % 4, $random(seed));
    end
    finish_test("random mix");

    $display("%0d tests, %0d passed, %0d errors", tests, passed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: icache.f
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_lru.sv
icache_lookup.sv
icache_miss_ctrl.sv
icache.sv
icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_tag_array.sv
  - icache_data_array.sv
  - icache_lru.sv
  - icache_lookup.sv
  - icache_miss_ctrl.sv
  - icache.sv
  - target: test
    files:
      - icache_tb.sv
